/* Bender.yml */
package:
  name: ex_trace

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ex_trace_pkg.sv
      - verilog/trace_fifo_if.sv
      - verilog/history_query_if.sv
      - verilog/trace_fifo.sv
      - verilog/signal_history.sv
      - verilog/ex_tracker.sv
      - verilog/ex_trace_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_ex_trace.sv

/* tests/ex_trace_input.txt */
# S id_valid tag id_end pass ex_ready data_mem_req, one line per cycle from reset release
# E tag pass ex_start ex_end mem_used mem_start mem_end, then O with the final id_overflow
S 0 0 0 0 1 0
S 0 0 0 0 1 0
S 0 0 0 0 0 0
S 0 0 0 0 1 0
S 0 0 0 0 1 1
S 0 0 0 0 0 0
S 1 1 1 0 0 0
S 1 2 5 1 0 0
S 1 3 2 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 1 0
S 0 0 0 0 1 0
S 0 0 0 0 1 0
S 0 0 0 0 0 1
S 0 0 0 0 0 1
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 0 0
S 1 4 22 0 0 0
S 0 0 0 0 0 0
S 1 5 24 1 0 0
S 1 6 27 0 0 0
S 1 7 29 1 0 0
S 1 8 28 0 0 0
S 1 9 31 0 0 0
S 0 0 0 0 0 0
S 0 0 0 0 1 0
S 0 0 0 0 1 1
S 0 0 0 0 0 1
S 0 0 0 0 0 1
S 0 0 0 0 1 1
S 0 0 0 0 1 1
S 0 0 0 0 1 0
S 0 0 0 0 0 0
S 0 0 0 0 1 0
S 0 0 0 0 1 1
S 0 0 0 0 0 0
E 1 0 3 4 1 4 4
E 2 1 0 0 0 0 0
E 3 0 18 20 0 0 0
E 4 0 34 35 1 35 39
E 5 1 0 0 0 0 0
E 6 0 38 40 0 0 0
E 7 1 0 0 0 0 0
E 8 0 42 43 1 43 43
O 1

/* tests/tb_ex_trace.sv */
`timescale 1ns/1ps
`include "ex_trace_config.svh"

module tb_ex_trace;

    localparam int STIM_MAX = 256;
    localparam int EXP_MAX  = 64;

    typedef struct packed {
        logic                  valid;
        logic [`EX_TAG_W-1:0]  tag;
        logic [`EX_TIME_W-1:0] id_end;
        logic                  pass;
        logic                  ex_ready;
        logic                  mem_req;
    } stim_t;

    typedef struct packed {
        logic [`EX_TAG_W-1:0]  tag;
        logic                  pass;
        logic [`EX_TIME_W-1:0] ex_start;
        logic [`EX_TIME_W-1:0] ex_end;
        logic                  mem_used;
        logic [`EX_TIME_W-1:0] mem_start;
        logic [`EX_TIME_W-1:0] mem_end;
    } exp_t;

    logic                  clk;
    logic                  arst_n_i;
    logic                  id_valid_i;
    logic [`EX_TAG_W-1:0]  id_tag_i;
    logic [`EX_TIME_W-1:0] id_end_i;
    logic                  id_pass_i;
    logic                  ex_ready_i;
    logic                  data_mem_req_i;
    logic                  ex_valid_o;
    logic [`EX_TAG_W-1:0]  ex_tag_o;
    logic                  ex_pass_o;
    logic [`EX_TIME_W-1:0] ex_start_o;
    logic [`EX_TIME_W-1:0] ex_end_o;
    logic                  mem_used_o;
    logic [`EX_TIME_W-1:0] mem_start_o;
    logic [`EX_TIME_W-1:0] mem_end_o;
    logic                  id_overflow_o;

    stim_t stim_mem [0:STIM_MAX-1];
    exp_t  exp_mem [0:EXP_MAX-1];
    logic  exp_overflow;
    int    n_stim;
    int    n_exp;
    int    n_seen;
    int    cycle_cnt;
    int    limit;

    ex_trace_top UUT (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .id_valid_i     (id_valid_i),
        .id_tag_i       (id_tag_i),
        .id_end_i       (id_end_i),
        .id_pass_i      (id_pass_i),
        .ex_ready_i     (ex_ready_i),
        .data_mem_req_i (data_mem_req_i),
        .ex_valid_o     (ex_valid_o),
        .ex_tag_o       (ex_tag_o),
        .ex_pass_o      (ex_pass_o),
        .ex_start_o     (ex_start_o),
        .ex_end_o       (ex_end_o),
        .mem_used_o     (mem_used_o),
        .mem_start_o    (mem_start_o),
        .mem_end_o      (mem_end_o),
        .id_overflow_o  (id_overflow_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        if (arst_n_i)
        begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic require_fields(input integer got, input integer want);
        if (got != want)
        begin
            $display("A line of tests/ex_trace_input.txt holds %0d fields where %0d are needed",
                     got, want);
            abort_run();
        end
    endtask

    // Lines start with S for one stimulus cycle, E for an expected record, O for the overflow flag
    task automatic load_vectors();
        integer fd;
        integer ch;
        integer code;
        integer f0, f1, f2, f3, f4, f5, f6;
        stim_t  s;
        exp_t   e;
        fd = $fopen("tests/ex_trace_input.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the stimulus file tests/ex_trace_input.txt");
            abort_run();
        end
        ch = $fgetc(fd);
        while (ch != -1)
        begin
            if (ch == "#")
            begin
                while ((ch != -1) && (ch != "\n"))
                begin
                    ch = $fgetc(fd);
                end
            end
            else if (ch == "S")
            begin
                code = $fscanf(fd, " %d %d %d %d %d %d", f0, f1, f2, f3, f4, f5);
                require_fields(code, 6);
                s.valid    = f0[0];
                s.tag      = f1[`EX_TAG_W-1:0];
                s.id_end   = f2;
                s.pass     = f3[0];
                s.ex_ready = f4[0];
                s.mem_req  = f5[0];
                stim_mem[n_stim] = s;
                n_stim++;
            end
            else if (ch == "E")
            begin
                code = $fscanf(fd, " %d %d %d %d %d %d %d", f0, f1, f2, f3, f4, f5, f6);
                require_fields(code, 7);
                e.tag       = f0[`EX_TAG_W-1:0];
                e.pass      = f1[0];
                e.ex_start  = f2;
                e.ex_end    = f3;
                e.mem_used  = f4[0];
                e.mem_start = f5;
                e.mem_end   = f6;
                exp_mem[n_exp] = e;
                n_exp++;
            end
            else if (ch == "O")
            begin
                code = $fscanf(fd, " %d", f0);
                require_fields(code, 1);
                exp_overflow = f0[0];
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic apply_line(input stim_t s);
        id_valid_i     = s.valid;
        id_tag_i       = s.tag;
        id_end_i       = s.id_end;
        id_pass_i      = s.pass;
        ex_ready_i     = s.ex_ready;
        data_mem_req_i = s.mem_req;
    endtask

    task automatic check_field(input string name, input logic [`EX_TIME_W-1:0] got,
                               input logic [`EX_TIME_W-1:0] want);
        assert (got === want)
        else
        begin
            $display("ERR %0t: record %0d field %s is %0d, expected %0d",
                     $time, n_seen, name, got, want);
            abort_run();
        end
    endtask

    // Outputs come from registers, so the middle of the cycle is a quiet place to look
    always @(negedge clk)
    begin
        if (arst_n_i && ex_valid_o)
        begin
            if (n_seen >= n_exp)
            begin
                $display("An extra output record with tag %0d appeared at %0t", ex_tag_o, $time);
                abort_run();
            end
            else
            begin
                check_field("tag", ex_tag_o, exp_mem[n_seen].tag);
                check_field("pass", ex_pass_o, exp_mem[n_seen].pass);
                check_field("ex_start", ex_start_o, exp_mem[n_seen].ex_start);
                check_field("ex_end", ex_end_o, exp_mem[n_seen].ex_end);
                check_field("mem_used", mem_used_o, exp_mem[n_seen].mem_used);
                check_field("mem_start", mem_start_o, exp_mem[n_seen].mem_start);
                check_field("mem_end", mem_end_o, exp_mem[n_seen].mem_end);
                n_seen++;
            end
        end
    end

    initial
    begin
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        apply_line('0);
        exp_overflow = 1'b0;
        n_stim       = 0;
        n_exp        = 0;
        n_seen       = 0;
        cycle_cnt    = 0;
        load_vectors();
        limit = n_stim + 50;
        repeat (10) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        // Line i is sampled at the edge where the DUT cycle counter reads i
        for (int i = 0; i < n_stim; i++)
        begin
            apply_line(stim_mem[i]);
            @(posedge clk);
            #2;
        end
        apply_line('0);
        while ((n_seen < n_exp) && (cycle_cnt < limit))
        begin
            @(posedge clk);
        end
        if (n_seen < n_exp)
        begin
            $display("Timeout after %0d cycles, only %0d of %0d output records arrived",
                     cycle_cnt, n_seen, n_exp);
            abort_run();
        end
        else
        begin
            repeat (4) @(posedge clk);
            assert (id_overflow_o === exp_overflow)
            else
            begin
                $display("ERR %0t: id_overflow_o is %0b, expected %0b",
                         $time, id_overflow_o, exp_overflow);
                abort_run();
            end
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/ex_trace_pkg.sv
verilog/trace_fifo_if.sv
verilog/history_query_if.sv
verilog/trace_fifo.sv
verilog/signal_history.sv
verilog/ex_tracker.sv
verilog/ex_trace_top.sv
tests/tb_ex_trace.sv

/* verilog/ex_trace_config.svh */
`ifndef EX_TRACE_CONFIG_SVH
`define EX_TRACE_CONFIG_SVH

// Width of every timestamp and of the free-running cycle counter
`define EX_TIME_W 32

// Width of the instruction tag carried through from decode
`define EX_TAG_W 8

// Records that can wait between decode and the execute tracker
`define EX_FIFO_DEPTH 4

// High runs kept per tracked signal, older runs are overwritten
`define EX_HIST_DEPTH 4

`endif

/* verilog/ex_trace_pkg.sv */
`include "ex_trace_config.svh"

package ex_trace_pkg;

    // One instruction as it moves from decode through the execute tracker
    typedef struct packed {
        logic [`EX_TAG_W-1:0]  tag;
        logic                  pass_through;
        logic [`EX_TIME_W-1:0] id_end;
        logic [`EX_TIME_W-1:0] ex_start;
        logic [`EX_TIME_W-1:0] ex_end;
        logic                  mem_used;
        logic [`EX_TIME_W-1:0] mem_start;
        logic [`EX_TIME_W-1:0] mem_end;
    } trace_rec_t;

    // Measuring FSM of the execute tracker
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        EX_QUERY,
        EX_WAIT,
        MEM_QUERY,
        MEM_WAIT,
        EMIT
    } ex_state_t;

endpackage

/* verilog/ex_trace_top.sv */
`timescale 1ns/1ps
`include "ex_trace_config.svh"

module ex_trace_top
(
    input logic                   clk,
    input logic                   arst_n_i,
    input logic                   id_valid_i,
    input logic [`EX_TAG_W-1:0]   id_tag_i,
    input logic [`EX_TIME_W-1:0]  id_end_i,
    input logic                   id_pass_i,
    input logic                   ex_ready_i,
    input logic                   data_mem_req_i,
    output logic                  ex_valid_o,
    output logic [`EX_TAG_W-1:0]  ex_tag_o,
    output logic                  ex_pass_o,
    output logic [`EX_TIME_W-1:0] ex_start_o,
    output logic [`EX_TIME_W-1:0] ex_end_o,
    output logic                  mem_used_o,
    output logic [`EX_TIME_W-1:0] mem_start_o,
    output logic [`EX_TIME_W-1:0] mem_end_o,
    output logic                  id_overflow_o
);
    import ex_trace_pkg::*;

    trace_rec_t in_rec;
    trace_rec_t out_rec;

    trace_fifo_if    fifo_bus ();
    history_query_if ex_q ();
    history_query_if mem_q ();

    // Measured fields start at zero and are filled in by the tracker
    always_comb
    begin
        in_rec              = '0;
        in_rec.tag          = id_tag_i;
        in_rec.pass_through = id_pass_i;
        in_rec.id_end       = id_end_i;
    end

    assign fifo_bus.push     = id_valid_i;
    assign fifo_bus.push_rec = in_rec;

    trace_fifo record_fifo (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .fifo_io    (fifo_bus.fifo),
        .overflow_o (id_overflow_o)
    );

    signal_history #(.DEPTH(`EX_HIST_DEPTH)) ex_ready_hist (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .level_i  (ex_ready_i),
        .q_io     (ex_q.responder)
    );

    signal_history #(.DEPTH(`EX_HIST_DEPTH)) mem_req_hist (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .level_i  (data_mem_req_i),
        .q_io     (mem_q.responder)
    );

    ex_tracker tracker (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .fifo_io     (fifo_bus.reader),
        .ex_q_io     (ex_q.requester),
        .mem_q_io    (mem_q.requester),
        .out_valid_o (ex_valid_o),
        .out_rec_o   (out_rec)
    );

    assign ex_tag_o    = out_rec.tag;
    assign ex_pass_o   = out_rec.pass_through;
    assign ex_start_o  = out_rec.ex_start;
    assign ex_end_o    = out_rec.ex_end;
    assign mem_used_o  = out_rec.mem_used;
    assign mem_start_o = out_rec.mem_start;
    assign mem_end_o   = out_rec.mem_end;

endmodule

/* verilog/ex_tracker.sv */
`timescale 1ns/1ps
`include "ex_trace_config.svh"

module ex_tracker
(
    input logic                       clk,
    input logic                       arst_n_i,
    trace_fifo_if.reader              fifo_io,
    history_query_if.requester        ex_q_io,
    history_query_if.requester        mem_q_io,
    output logic                      out_valid_o,
    output ex_trace_pkg::trace_rec_t  out_rec_o
);
    import ex_trace_pkg::*;

    ex_state_t             state;
    trace_rec_t            rec;
    logic [`EX_TIME_W-1:0] counter;
    // First cycle the next execute run may start in, one past the last ex_end
    logic [`EX_TIME_W-1:0] ex_floor;
    logic [`EX_TIME_W-1:0] id_floor;
    logic                  ex_done;
    logic                  mem_miss;
    logic                  mem_done;

    assign id_floor = rec.id_end + 1'b1;

    assign ex_q_io.now    = counter;
    assign ex_q_io.bound  = (id_floor > ex_floor) ? id_floor : ex_floor;
    // Keep asking while waiting so every answer reflects the latest edges
    assign ex_q_io.query  = (state == EX_QUERY) || (state == EX_WAIT);

    assign mem_q_io.now   = counter;
    assign mem_q_io.bound = rec.ex_start;
    assign mem_q_io.query = (state == MEM_QUERY) || (state == MEM_WAIT);

    assign fifo_io.pop  = (state == IDLE) && fifo_io.not_empty;
    assign out_valid_o  = (state == EMIT);
    assign out_rec_o    = rec;

    assign ex_done  = ex_q_io.start_found && ex_q_io.end_found;
    // No request run, or the first one begins after execute has finished
    assign mem_miss = !mem_q_io.start_found || (mem_q_io.run_start > rec.ex_end);
    assign mem_done = mem_q_io.end_found;

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state    <= IDLE;
            counter  <= '0;
            ex_floor <= '0;
        end
        else
        begin
            counter <= counter + 1'b1;
            case (state)
                IDLE:
                begin
                    if (fifo_io.not_empty)
                    begin
                        state <= FETCH;
                    end
                end
                FETCH:
                begin
                    state <= rec.pass_through ? EMIT : EX_QUERY;
                end
                EX_QUERY:
                begin
                    state <= EX_WAIT;
                end
                EX_WAIT:
                begin
                    if (ex_done)
                    begin
                        state <= MEM_QUERY;
                    end
                end
                MEM_QUERY:
                begin
                    state <= MEM_WAIT;
                end
                MEM_WAIT:
                begin
                    if (mem_miss || mem_done)
                    begin
                        state <= EMIT;
                    end
                end
                EMIT:
                begin
                    // Pass-through records carry no execute run
                    if (!rec.pass_through)
                    begin
                        ex_floor <= rec.ex_end + 1'b1;
                    end
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            IDLE:
            begin
                if (fifo_io.not_empty)
                begin
                    rec <= fifo_io.head_rec;
                end
            end
            EX_WAIT:
            begin
                if (ex_done)
                begin
                    rec.ex_start <= ex_q_io.run_start;
                    rec.ex_end   <= ex_q_io.run_end;
                end
            end
            MEM_WAIT:
            begin
                if (mem_miss)
                begin
                    rec.mem_used  <= 1'b0;
                    rec.mem_start <= '0;
                    rec.mem_end   <= '0;
                end
                else if (mem_done)
                begin
                    rec.mem_used  <= 1'b1;
                    rec.mem_start <= mem_q_io.run_start;
                    rec.mem_end   <= mem_q_io.run_end;
                end
            end
            default:
            begin
            end
        endcase
    end

endmodule

/* verilog/history_query_if.sv */
`timescale 1ns/1ps
`include "ex_trace_config.svh"

interface history_query_if ();

    // Current cycle count, used by the history to stamp edges
    logic [`EX_TIME_W-1:0] now;
    logic                  query;
    logic [`EX_TIME_W-1:0] bound;
    logic                  start_found;
    // Stays low while the matching run is still high
    logic                  end_found;
    logic [`EX_TIME_W-1:0] run_start;
    logic [`EX_TIME_W-1:0] run_end;

    modport requester (output now, output query, output bound,
                       input start_found, input end_found, input run_start, input run_end);

    modport responder (input now, input query, input bound,
                       output start_found, output end_found, output run_start, output run_end);

endinterface

/* verilog/signal_history.sv */
`timescale 1ns/1ps
`include "ex_trace_config.svh"

module signal_history
#(
    parameter int DEPTH = `EX_HIST_DEPTH
)
(
    input logic                clk,
    input logic                arst_n_i,
    input logic                level_i,
    history_query_if.responder q_io
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [`EX_TIME_W-1:0] run_start_q [DEPTH];
    logic [`EX_TIME_W-1:0] run_end_q [DEPTH];
    logic [DEPTH-1:0]      run_valid;
    logic [DEPTH-1:0]      run_closed;
    logic [IDX_W-1:0]      wr_ptr;
    logic [IDX_W-1:0]      last_idx;
    logic                  level_q;
    logic                  rise;
    logic                  fall;
    logic                  hit;
    logic [IDX_W-1:0]      hit_idx;

    assign rise = level_i && !level_q;
    assign fall = !level_i && level_q;

    // The entry at wr_ptr is the oldest run and is the one a new rise replaces
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            level_q    <= 1'b0;
            wr_ptr     <= '0;
            last_idx   <= '0;
            run_valid  <= '0;
            run_closed <= '0;
        end
        else
        begin
            level_q <= level_i;
            if (rise)
            begin
                run_valid[wr_ptr]  <= 1'b1;
                run_closed[wr_ptr] <= 1'b0;
                last_idx           <= wr_ptr;
                wr_ptr             <= (wr_ptr == IDX_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fall)
            begin
                run_closed[last_idx] <= 1'b1;
            end
        end
    end

    // A fall is seen one cycle after the last high cycle
    always_ff @(posedge clk)
    begin
        if (rise)
        begin
            run_start_q[wr_ptr] <= q_io.now;
        end
        if (fall)
        begin
            run_end_q[last_idx] <= q_io.now - 1'b1;
        end
    end

    // Walk the ring from oldest to newest and take the first run at or after bound
    always_comb
    begin : scan_ring
        logic [IDX_W-1:0] idx;
        hit     = 1'b0;
        hit_idx = '0;
        idx     = wr_ptr;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (!hit && run_valid[idx] && (run_start_q[idx] >= q_io.bound))
            begin
                hit     = 1'b1;
                hit_idx = idx;
            end
            idx = (idx == IDX_W'(DEPTH - 1)) ? '0 : idx + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            q_io.start_found <= 1'b0;
            q_io.end_found   <= 1'b0;
        end
        else if (q_io.query)
        begin
            q_io.start_found <= hit;
            q_io.end_found   <= hit && run_closed[hit_idx];
        end
    end

    always_ff @(posedge clk)
    begin
        if (q_io.query)
        begin
            q_io.run_start <= run_start_q[hit_idx];
            q_io.run_end   <= run_closed[hit_idx] ? run_end_q[hit_idx] : '0;
        end
    end

endmodule

/* verilog/trace_fifo.sv */
`timescale 1ns/1ps
`include "ex_trace_config.svh"

module trace_fifo
(
    input logic        clk,
    input logic        arst_n_i,
    trace_fifo_if.fifo fifo_io,
    output logic       overflow_o
);
    import ex_trace_pkg::*;

    localparam int DEPTH = `EX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    trace_rec_t       mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    // Pushes into a full buffer are lost, the overflow flag records it
    assign do_push = fifo_io.push && !full;
    assign do_pop  = fifo_io.pop && fifo_io.not_empty;

    assign fifo_io.not_empty = (count != '0);
    assign fifo_io.head_rec  = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
            if (fifo_io.push && full)
            begin
                overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= fifo_io.push_rec;
        end
    end

endmodule

/* verilog/trace_fifo_if.sv */
`timescale 1ns/1ps

interface trace_fifo_if ();
    import ex_trace_pkg::*;

    logic       push;
    trace_rec_t push_rec;
    logic       pop;
    logic       not_empty;
    // Head entry, meaningful only while not_empty is high
    trace_rec_t head_rec;

    modport writer (output push, output push_rec);

    modport reader (output pop, input not_empty, input head_rec);

    modport fifo (input push, input push_rec, input pop, output not_empty, output head_rec);

endinterface
